//--- flist.f
+incdir+include
source/avl_bus_pkg.sv
source/avl_out_if.sv
source/avl_bus_priority_encoder.sv
source/avl_bus_n21_arb.sv
source/avl_bus_cmd_mux.sv
source/avl_bus_rsp_route.sv
source/avl_bus_n21.sv
tb/avl_bus_tb.sv

//--- include/avl_bus_define.svh
`ifndef AVL_BUS_DEFINE_SVH
`define AVL_BUS_DEFINE_SVH

// longest burst a master may issue, counted in beats.
// the burst_count field carries the beats after the first one,
// so its width follows from this limit.
`define ALV_BURST_MAX_COUNT 8

`endif

//--- run.sh
#!/bin/sh
# build with Verilator, run, and judge the run by its log.
rm -f sim.log
verilator --binary --timing -f flist.f --top-module avl_bus_tb -o avl_bus_sim &&
  ./obj_dir/avl_bus_sim | tee sim.log
grep -q "Finished with no errors" sim.log && echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

//--- source/avl_bus_cmd_mux.sv
`timescale 1ns/1ps

module avl_bus_cmd_mux (
  input  avl_bus_pkg::sel_t                  sel,
  input  avl_bus_pkg::avl_cmd_t              m_cmd [avl_bus_pkg::MASTER_NUM],
  output logic [avl_bus_pkg::MASTER_NUM-1:0] m_ready,
  output logic [avl_bus_pkg::MASTER_NUM-1:0] request,
  avl_out_if.mux                             bus
);
  import avl_bus_pkg::*;

  // a master requests while it holds read or write.
  always_comb begin
    for (int k = 0; k < MASTER_NUM; k++) begin
      request[k] = m_cmd[k].read || m_cmd[k].write;
    end
  end

  // forward the granted command as it stands.
  // when the granted master is idle the strobes go low,
  // so no stray begin flag reaches the slave or the arbiter.
  always_comb begin
    bus.cmd = m_cmd[sel];
    if (!request[sel]) begin
      bus.cmd.read = 1'b0;
      bus.cmd.write = 1'b0;
      bus.cmd.begin_burst_transfer = 1'b0;
    end
  end

  // wait states go back to the granted master only.
  always_comb begin
    m_ready = '0;
    m_ready[sel] = bus.request_ready; // others see ready low.
  end

endmodule

//--- source/avl_bus_n21.sv
`timescale 1ns/1ps

module avl_bus_n21 (
  input  logic                               clk,
  input  logic                               rest,
  input  logic [avl_bus_pkg::MASTER_NUM-1:0] m_read,
  input  logic [avl_bus_pkg::MASTER_NUM-1:0] m_write,
  input  logic [avl_bus_pkg::MASTER_NUM-1:0] m_begin_burst_transfer,
  input  avl_bus_pkg::burst_t                m_burst_count [avl_bus_pkg::MASTER_NUM],
  input  avl_bus_pkg::addr_t                 m_address [avl_bus_pkg::MASTER_NUM],
  input  avl_bus_pkg::data_t                 m_writedata [avl_bus_pkg::MASTER_NUM],
  output logic [avl_bus_pkg::MASTER_NUM-1:0] m_ready,
  output logic [avl_bus_pkg::MASTER_NUM-1:0] m_readdatavalid,
  output avl_bus_pkg::data_t                 m_readdata,
  output logic                               s_read,
  output logic                               s_write,
  output logic                               s_begin_burst_transfer,
  output avl_bus_pkg::burst_t                s_burst_count,
  output avl_bus_pkg::addr_t                 s_address,
  output avl_bus_pkg::data_t                 s_writedata,
  input  logic                               s_request_ready,
  input  logic                               s_readdatavalid,
  input  avl_bus_pkg::data_t                 s_readdata
);
  import avl_bus_pkg::*;

  avl_cmd_t m_cmd [MASTER_NUM]; // master fields gathered per master.
  logic [MASTER_NUM-1:0] request;
  sel_t sel;
  logic rsp_full; // tag queue cannot take another read.

  avl_out_if bus ();

  always_comb begin
    for (int k = 0; k < MASTER_NUM; k++) begin
      m_cmd[k].read = m_read[k];
      m_cmd[k].write = m_write[k];
      m_cmd[k].begin_burst_transfer = m_begin_burst_transfer[k];
      m_cmd[k].burst_count = m_burst_count[k];
      m_cmd[k].address = m_address[k];
      m_cmd[k].writedata = m_writedata[k];
    end
  end

  // a full tag queue refuses reads, both toward the masters and the slave.
  assign bus.request_ready = s_request_ready && !(rsp_full && bus.cmd.read);
  assign s_read = bus.cmd.read && !rsp_full; // the slave never takes an untracked read.
  assign s_write = bus.cmd.write;
  assign s_begin_burst_transfer = bus.cmd.begin_burst_transfer;
  assign s_burst_count = bus.cmd.burst_count;
  assign s_address = bus.cmd.address;
  assign s_writedata = bus.cmd.writedata;

  avl_bus_n21_arb u_arb (
    .clk     (clk),
    .rest    (rest),
    .request (request),
    .bus     (bus.arb),
    .sel     (sel)
  );

  avl_bus_cmd_mux u_mux (
    .sel     (sel),
    .m_cmd   (m_cmd),
    .m_ready (m_ready),
    .request (request),
    .bus     (bus.mux)
  );

  avl_bus_rsp_route u_rsp (
    .clk             (clk),
    .rest            (rest),
    .sel             (sel),
    .bus             (bus.rsp),
    .s_readdata      (s_readdata),
    .s_readdatavalid (s_readdatavalid),
    .m_readdata      (m_readdata),
    .m_readdatavalid (m_readdatavalid),
    .full            (rsp_full)
  );

endmodule

//--- source/avl_bus_n21_arb.sv
`timescale 1ns/1ps

module avl_bus_n21_arb (
  input  logic                               clk,
  input  logic                               rest,
  input  logic [avl_bus_pkg::MASTER_NUM-1:0] request,
  avl_out_if.arb                             bus,
  output avl_bus_pkg::sel_t                  sel
);
  import avl_bus_pkg::*;

  logic [MASTER_NUM-1:0] rotated; // requests, starting after the last grant.
  sel_t enc_out; // position of the first requester in the rotated vector.
  sel_t rr_sel; // round-robin choice in real master numbering.
  sel_t last_sel; // master that finished the latest transfer.
  sel_t sel_buff; // grant held during a burst or a stall.
  burst_t burst_cnt; // follow-on beats still owed by the burst owner.
  logic stall_q; // a command waited on ready in the previous cycle.
  logic cmd_valid; // the granted master presents a beat.
  logic accept; // the slave takes the beat this cycle.
  logic burst_start; // accepted first beat of a multi-beat burst.
  logic xfer_end; // accepted beat closes a transfer.

  assign cmd_valid = bus.cmd.read || bus.cmd.write;
  assign accept = bus.request_ready && cmd_valid; // acceptance rule.

  // only a begin beat with a nonzero count opens a burst.
  assign burst_start = accept && (burst_cnt == '0) && bus.cmd.begin_burst_transfer &&
                       (bus.cmd.burst_count != '0);

  // a lone beat, or the last beat of a running burst, ends the transfer.
  assign xfer_end = accept && ((burst_cnt == burst_t'(1)) ||
                               ((burst_cnt == '0) && !burst_start));

  // rotate so that the master after last_sel lands on bit 0.
  always_comb begin
    for (int i = 0; i < MASTER_NUM; i++) begin
      rotated[i] = request[sel_t'(last_sel + sel_t'(i + 1))];
    end
  end

  avl_bus_priority_encoder u_enc (
    .in  (rotated),
    .out (enc_out)
  );

  // add the rotation offset back; sel_t wraps modulo the master count.
  assign rr_sel = enc_out + last_sel + sel_t'(1);

  // the grant is frozen while a burst runs or a beat waits on ready.
  assign sel = ((burst_cnt != '0) || stall_q) ? sel_buff : rr_sel;

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      burst_cnt <= '0;
      sel_buff <= '0;
      stall_q <= 1'b0;
    end else begin
      stall_q <= cmd_valid && !bus.request_ready; // back-pressure holds the grant.
      if (cmd_valid) begin
        sel_buff <= sel; // keep whoever currently drives the bus.
      end
      if (burst_start) begin
        burst_cnt <= bus.cmd.burst_count;
      end else if (accept && (burst_cnt != '0)) begin
        burst_cnt <= burst_cnt - burst_t'(1); // one follow-on beat done.
      end
    end
  end

  // reset to the top index so master 0 is served first.
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      last_sel <= sel_t'(MASTER_NUM - 1);
    end else if (xfer_end) begin
      last_sel <= sel;
    end
  end

endmodule

//--- source/avl_bus_pkg.sv
`include "avl_bus_define.svh"

package avl_bus_pkg;

  // number of masters sharing the slave.
  localparam int MASTER_NUM = 4;
  localparam int SEL_WIDTH = $clog2(MASTER_NUM); // bits of a master index.

  localparam int ADDR_WIDTH = 16; // byte address seen by the slave.
  localparam int DATA_WIDTH = 32; // one data word per beat.

  // follow-on beats of a burst fit in this many bits.
  localparam int BURST_WIDTH = $clog2(`ALV_BURST_MAX_COUNT);

  // reads the slave may hold before any of their data comes back.
  localparam int RSP_DEPTH = 8;
  localparam int RSP_PTR_WIDTH = $clog2(RSP_DEPTH); // index into the tag queue.
  localparam int RSP_CNT_WIDTH = RSP_PTR_WIDTH + 1; // occupancy, 0 to RSP_DEPTH.

  typedef logic [SEL_WIDTH-1:0] sel_t; // master index.
  typedef logic [ADDR_WIDTH-1:0] addr_t; // address.
  typedef logic [DATA_WIDTH-1:0] data_t; // data word.
  typedef logic [BURST_WIDTH-1:0] burst_t; // beats after the first.

  // one command beat as a master presents it.
  // read and write are levels, and at most one of them is set.
  typedef struct packed {
    logic read;
    logic write;
    logic begin_burst_transfer; // marks the first beat of a burst.
    burst_t burst_count; // beats that follow this one.
    addr_t address;
    data_t writedata;
  } avl_cmd_t;

endpackage

//--- source/avl_bus_priority_encoder.sv
`timescale 1ns/1ps

module avl_bus_priority_encoder (
  input  logic [avl_bus_pkg::MASTER_NUM-1:0] in,
  output avl_bus_pkg::sel_t                  out
);
  import avl_bus_pkg::*;

  // the lowest set bit wins.
  // scanning from the top down lets the last hit be the lowest one.
  always_comb begin
    out = '0; // no bit set gives index zero.
    for (int i = MASTER_NUM - 1; i >= 0; i--) begin
      if (in[i]) begin
        out = sel_t'(i);
      end
    end
  end

endmodule

//--- source/avl_bus_rsp_route.sv
`timescale 1ns/1ps

module avl_bus_rsp_route (
  input  logic                               clk,
  input  logic                               rest,
  input  avl_bus_pkg::sel_t                  sel,
  avl_out_if.rsp                             bus,
  input  avl_bus_pkg::data_t                 s_readdata,
  input  logic                               s_readdatavalid,
  output avl_bus_pkg::data_t                 m_readdata,
  output logic [avl_bus_pkg::MASTER_NUM-1:0] m_readdatavalid,
  output logic                               full
);
  import avl_bus_pkg::*;

  sel_t tag_mem [RSP_DEPTH]; // issuing master of each outstanding read.
  logic [RSP_PTR_WIDTH-1:0] wr_ptr;
  logic [RSP_PTR_WIDTH-1:0] rd_ptr;
  logic [RSP_CNT_WIDTH-1:0] count; // reads still waiting for data.
  logic push; // an accepted read this cycle.
  sel_t head; // owner of the next read datum.

  assign push = bus.request_ready && bus.cmd.read;
  assign full = (count == RSP_CNT_WIDTH'(RSP_DEPTH));

  // with an empty queue the data may come back in the accepting cycle,
  // so the head then comes straight from the grant.
  assign head = (count == '0) ? sel : tag_mem[rd_ptr];

  assign m_readdata = s_readdata; // every master sees the data, valid picks one.

  always_comb begin
    m_readdatavalid = '0;
    m_readdatavalid[head] = s_readdatavalid;
  end

  // the granted index goes into the slot at the write pointer when a read is accepted.
  always_ff @(posedge clk) begin
    if (push) begin
      tag_mem[wr_ptr] <= sel;
    end
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1; // wraps at RSP_DEPTH.
      end
      if (s_readdatavalid) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + RSP_CNT_WIDTH'(push) - RSP_CNT_WIDTH'(s_readdatavalid);
    end
  end

endmodule

//--- source/avl_out_if.sv
`timescale 1ns/1ps

// slave-side command path shared by the mux, the arbiter and the router.
interface avl_out_if;
  import avl_bus_pkg::*;

  avl_cmd_t cmd; // command of the granted master.
  logic request_ready; // slave ready, already gated for a full response queue.

  // the mux owns the command and sees ready.
  modport mux (output cmd, input request_ready);

  // the arbiter watches accepted beats to track bursts.
  modport arb (input cmd, input request_ready);

  // the router watches accepted reads to queue their tags.
  modport rsp (input cmd, input request_ready);

  // the top level joins both to its plain slave ports.
  modport top (output request_ready, input cmd);

endinterface

//--- tb/avl_bus_tb.sv
`timescale 1ns/1ps

module avl_bus_tb;
  import avl_bus_pkg::*;

  localparam int TX_PER_MASTER = 24; // transfers each master issues.
  localparam int CYCLE_LIMIT = 40 * MASTER_NUM * TX_PER_MASTER; // 40 cycles per transfer.
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic clk = 1'b0;
  logic rest;
  logic [MASTER_NUM-1:0] m_read, m_write, m_begin_burst_transfer;
  burst_t m_burst_count [MASTER_NUM];
  addr_t m_address [MASTER_NUM];
  data_t m_writedata [MASTER_NUM];
  logic [MASTER_NUM-1:0] m_ready, m_readdatavalid;
  data_t m_readdata;
  logic s_read, s_write, s_begin_burst_transfer;
  burst_t s_burst_count;
  addr_t s_address;
  data_t s_writedata, s_readdata;
  logic s_request_ready, s_readdatavalid;

  logic [31:0] lfsr = 32'h69663079;
  int left_tx [MASTER_NUM]; // transfers a master has yet to start.
  int beats_left [MASTER_NUM]; // beats after the one on the bus now.
  logic active [MASTER_NUM]; // the master presents a command.
  logic accepted [MASTER_NUM]; // set by the compare process at the edge.
  data_t ref_mem [addr_t]; // memory as the reference sees it.
  data_t slave_mem [addr_t]; // memory inside the slave model.
  data_t slave_q [$]; // read data the slave still owes, in order.
  int owners [$]; // issuing master of each outstanding read.
  data_t exp_data [MASTER_NUM][$]; // expected read data per master.
  int last_grant = MASTER_NUM - 1;
  int burst_left = 0; // follow-on beats the burst owner still owes.
  int held_grant = 0;
  logic grant_held = 1'b0; // a refused beat keeps its grant.

  avl_bus_n21 DUT (.*);

  initial begin
    forever #50 clk = ~clk;
  end

  // one step of the Galois LFSR per bit taken.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
    end
    return val;
  endfunction

  // unwritten words hold a pattern made from the full address.
  function automatic data_t fill_word(input addr_t a);
    return {a ^ 16'hc35a, ~a};
  endfunction

  // first requester after the last grant, counting circularly.
  function automatic int next_grant(input logic [MASTER_NUM-1:0] req, input int last);
    int cand;
    for (int i = 1; i <= MASTER_NUM; i++) begin
      cand = (last + i) % MASTER_NUM;
      if (req[cand]) begin
        return cand;
      end
    end
    return -1; // nobody requests.
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
      $display("Finished with errors");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // advance master k after an accepted beat, or start a new transfer.
  task automatic drive_master(input int k);
    if (active[k] && accepted[k]) begin
      if (beats_left[k] > 0) begin
        beats_left[k]--; // next beat follows without a gap.
        m_begin_burst_transfer[k] = 1'b0;
        m_burst_count[k] = '0;
        m_address[k] = m_address[k] + addr_t'(4);
        m_writedata[k] = take_bits(32);
      end else begin
        active[k] = 1'b0;
      end
    end
    if (!active[k]) begin
      m_read[k] = 1'b0;
      m_write[k] = 1'b0;
      m_begin_burst_transfer[k] = 1'b0;
      if (left_tx[k] > 0 && take_bits(2) != 0) begin
        m_read[k] = (take_bits(1) != 0);
        m_write[k] = !m_read[k];
        m_begin_burst_transfer[k] = (take_bits(1) != 0); // half are bursts, a few of one beat.
        beats_left[k] = m_begin_burst_transfer[k] ? int'(take_bits(3)) : 0;
        m_burst_count[k] = burst_t'(beats_left[k]);
        m_address[k] = addr_t'({take_bits(4), 2'b00}); // sixteen words, so reads hit writes.
        m_writedata[k] = take_bits(32);
        active[k] = 1'b1;
        left_tx[k]--;
      end
    end
  endtask

  task automatic drive_slave();
    s_request_ready = (take_bits(2) != 0); // ready in about three cycles of four.
    if (slave_q.size() != 0 && take_bits(1) != 0) begin
      s_readdatavalid = 1'b1; // random latency of one cycle or more.
      s_readdata = slave_q.pop_front();
    end else begin
      s_readdatavalid = 1'b0;
    end
  endtask

  function automatic logic all_done();
    for (int k = 0; k < MASTER_NUM; k++) begin
      if (active[k] || left_tx[k] != 0 || exp_data[k].size() != 0) begin
        return 1'b0;
      end
    end
    return (owners.size() == 0) && (slave_q.size() == 0);
  endfunction

  // slave model takes beats off its own port.
  always @(posedge clk) begin
    if (rest && s_request_ready) begin
      if (s_write) begin
        slave_mem[s_address] = s_writedata;
      end
      if (s_read) begin
        slave_q.push_back(slave_mem.exists(s_address) ? slave_mem[s_address] :
                          fill_word(s_address));
      end
    end
  end

  always @(posedge clk) begin : compare_bus
    logic [MASTER_NUM-1:0] req;
    logic full;
    logic rdy;
    int g;
    int owner;
    if (!rest) begin
      check_value("m_ready", 32'(m_ready), 32'h0);
      check_value("m_readdatavalid", 32'(m_readdatavalid), 32'h0);
      last_grant = MASTER_NUM - 1; // master 0 is first after reset.
      burst_left = 0;
      grant_held = 1'b0;
    end else begin
      req = m_read | m_write;
      full = (owners.size() == RSP_DEPTH); // tag queue as it stood before this edge.
      for (int k = 0; k < MASTER_NUM; k++) begin
        accepted[k] = 1'b0;
      end
      if (s_readdatavalid) begin
        owner = owners.pop_front(); // the oldest read owns this datum.
        check_value("m_readdatavalid", 32'(m_readdatavalid), 32'(1) << owner);
        check_value("m_readdata", m_readdata, exp_data[owner].pop_front());
      end else begin
        check_value("m_readdatavalid", 32'(m_readdatavalid), 32'h0);
      end
      if (req == '0) begin
        // with no requester the grant rests on the master after the last grant.
        check_value("m_ready", 32'(m_ready),
                    32'(s_request_ready) << ((last_grant + 1) % MASTER_NUM));
        check_value("s_read", 32'(s_read), 32'h0);
        check_value("s_write", 32'(s_write), 32'h0);
        grant_held = 1'b0;
      end else begin
        g = (burst_left != 0 || grant_held) ? held_grant : next_grant(req, last_grant);
        rdy = s_request_ready && !(m_read[g] && full); // reads wait while the queue is full.
        check_value("m_ready", 32'(m_ready), 32'(rdy) << g);
        check_value("s_read", 32'(s_read), 32'(m_read[g] && !full));
        check_value("s_write", 32'(s_write), 32'(m_write[g]));
        check_value("s_begin_burst_transfer", 32'(s_begin_burst_transfer),
                    32'(m_begin_burst_transfer[g]));
        check_value("s_burst_count", 32'(s_burst_count), 32'(m_burst_count[g]));
        check_value("s_address", 32'(s_address), 32'(m_address[g]));
        check_value("s_writedata", s_writedata, m_writedata[g]);
        held_grant = g;
        grant_held = !rdy;
        if (rdy) begin
          accepted[g] = 1'b1;
          if (m_write[g]) begin
            ref_mem[m_address[g]] = m_writedata[g];
          end else begin
            owners.push_back(g);
            exp_data[g].push_back(ref_mem.exists(m_address[g]) ? ref_mem[m_address[g]] :
                                  fill_word(m_address[g]));
          end
          if (burst_left == 0 && m_begin_burst_transfer[g] && m_burst_count[g] != '0) begin
            burst_left = int'(m_burst_count[g]); // grant locks on the owner.
          end else begin
            if (burst_left <= 1) begin
              last_grant = g; // a single beat or the final burst beat.
            end
            if (burst_left > 0) begin
              burst_left--;
            end
          end
        end
      end
    end
  end

  initial begin : run_test
    int cycles;
    cycles = 0;
    rest = 1'b0;
    m_read = '0;
    m_write = '0;
    m_begin_burst_transfer = '0;
    s_request_ready = 1'b0;
    s_readdatavalid = 1'b0;
    s_readdata = '0;
    for (int k = 0; k < MASTER_NUM; k++) begin
      m_burst_count[k] = '0;
      m_address[k] = '0;
      m_writedata[k] = '0;
      left_tx[k] = TX_PER_MASTER;
      beats_left[k] = 0;
      active[k] = 1'b0;
      accepted[k] = 1'b0;
    end
    repeat (3) @(negedge clk);
    rest = 1'b1;
    while (!all_done() && cycles < CYCLE_LIMIT) begin
      for (int k = 0; k < MASTER_NUM; k++) begin
        drive_master(k);
      end
      drive_slave();
      @(negedge clk);
      cycles++;
    end
    if (!all_done()) begin
      $display("timeout: transfers or read data still pending after %0d cycles", cycles);
      $display("Finished with errors");
      $fatal(1, "run stopped on timeout");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule
